// File: common/pixel_pkg.sv
package pixel_pkg;

	localparam int channel_w = 8;

	// one colour channel
	typedef logic [channel_w-1:0] channel_t;

	// 24-bit rgb pixel, red in the high byte
	typedef struct packed {
		channel_t red;
		channel_t green;
		channel_t blue;
	} pixel_t;

	// value 3 is illegal
	typedef enum logic [1:0] {
		color_red   = 2'd0,
		color_green = 2'd1,
		color_blue  = 2'd2
	} color_sel_e;

endpackage

// File: common/ctrl_pkg.sv
package ctrl_pkg;

	import pixel_pkg::*;

	// code 3 reserved, was divide
	typedef enum logic [1:0] {
		op_add = 2'd0,
		op_sub = 2'd1,
		op_mul = 2'd2
	} alu_op_e;

	typedef struct packed {
		alu_op_e    op;
		color_sel_e color;
		channel_t   scalar;
	} alu_cmd_t;

	// master side of axi4-lite
	typedef struct packed {
		logic [7:0]  awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
		logic [7:0]  araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	// slave side
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axil_rsp_t;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// register map
	localparam logic [7:0] addr_pixel_base  = 8'h00; // lane k at +4k
	localparam logic [7:0] addr_ctrl        = 8'h20;
	localparam logic [7:0] addr_status      = 8'h24;
	localparam logic [7:0] addr_result_base = 8'h40;

	// ctrl fields
	localparam int ctrl_scalar_lsb = 0;
	localparam int ctrl_op_lsb     = 8;
	localparam int ctrl_color_lsb  = 10;

	// status fields
	localparam int status_done_bit  = 0;
	localparam int status_carry_lsb = 8;

endpackage

// File: vector_alu/lane_alu.sv
`timescale 1ns/1ps

module lane_alu import pixel_pkg::*, ctrl_pkg::*; (
	input  pixel_t   pixel,
	input  alu_cmd_t cmd,
	output pixel_t   result,
	output logic     carry
);

	channel_t chan;
	channel_t chan_res;
	logic [8:0] sum;
	logic [8:0] diff;
	logic [15:0] prod;

	// pick the channel to work on
	always_comb begin
		case (cmd.color)
			color_red:   chan = pixel.red;
			color_green: chan = pixel.green;
			default:     chan = pixel.blue;
		endcase
	end

	assign sum  = {1'b0, chan} + {1'b0, cmd.scalar};
	assign diff = {1'b0, chan} - {1'b0, cmd.scalar}; // bit 8 is the borrow
	assign prod = chan * cmd.scalar;

	always_comb begin
		case (cmd.op)
			op_add: begin
				chan_res = sum[7:0];
				carry    = sum[8];
			end
			op_sub: begin
				chan_res = diff[7:0];
				carry    = diff[8];
			end
			op_mul: begin
				chan_res = prod[7:0];
				carry    = |prod[15:8]; // high byte lost
			end
			default: begin
				chan_res = chan;
				carry    = 1'b0;
			end
		endcase
	end

	// merge back, other channels untouched
	always_comb begin
		result = pixel;
		case (cmd.color)
			color_red:   result.red = chan_res;
			color_green: result.green = chan_res;
			default:     result.blue = chan_res;
		endcase
	end

endmodule

// File: vector_alu/vector_alu.sv
`timescale 1ns/1ps

module vector_alu import pixel_pkg::*, ctrl_pkg::*; #(
	parameter int lanes = 8
) (
	input  logic               clk,
	input  logic               rst_n,
	input  alu_cmd_t           cmd,
	input  pixel_t [lanes-1:0] pixels,
	input  logic               start,
	output pixel_t [lanes-1:0] results,
	output logic [lanes-1:0]   carry,
	output logic               done
);

	pixel_t [lanes-1:0] lane_res;
	logic [lanes-1:0] lane_carry;

	for (genvar i = 0; i < lanes; i++) begin : g_lane
		lane_alu u_lane (
			.pixel  (pixels[i]),
			.cmd    (cmd),
			.result (lane_res[i]),
			.carry  (lane_carry[i])
		);
	end

	// single result stage, a new start every cycle is fine
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			results <= '0;
			carry   <= '0;
			done    <= 1'b0;
		end else begin
			done <= start;
			if (start) begin
				results <= lane_res;
				carry   <= lane_carry;
			end
		end
	end

	// done exactly one cycle after start, never on its own
	a_done_timing: assert property (
		@(posedge clk) disable iff (!rst_n)
		done == $past(start)
	);

	// register block filters the reserved op
	a_no_reserved_op: assert property (
		@(posedge clk) disable iff (!rst_n)
		start |-> cmd.op inside {op_add, op_sub, op_mul}
	);

endmodule

// File: rtl/alu_regs.sv
`timescale 1ns/1ps

module alu_regs import pixel_pkg::*, ctrl_pkg::*; #(
	parameter int lanes = 8
) (
	input  logic               clk,
	input  logic               rst_n,
	input  axil_req_t          axil_req,
	output axil_rsp_t          axil_rsp,
	output alu_cmd_t           cmd,
	output pixel_t [lanes-1:0] pixels,
	output logic               start,
	input  pixel_t [lanes-1:0] results,
	input  logic [lanes-1:0]   carry,
	input  logic               done
);

	logic aw_ready_q;
	logic b_valid_q;
	logic [1:0] b_resp_q;
	logic ar_ready_q;
	logic r_valid_q;
	logic [1:0] r_resp_q;
	logic [31:0] r_data_q;
	logic done_q;

	logic wr_fire;
	logic rd_fire;
	logic [2:0] wr_idx;
	logic [2:0] rd_idx;
	logic wr_pixel;
	logic wr_ctrl;
	logic [1:0] wr_op;
	logic [1:0] wr_color;
	logic [31:0] rd_data;
	logic rd_err;
	logic [7:0] carry_byte;

	assign axil_rsp = '{
		awready: aw_ready_q,
		wready:  aw_ready_q,
		bresp:   b_resp_q,
		bvalid:  b_valid_q,
		arready: ar_ready_q,
		rdata:   r_data_q,
		rresp:   r_resp_q,
		rvalid:  r_valid_q
	};

	assign wr_fire = aw_ready_q && axil_req.awvalid && axil_req.wvalid;
	assign rd_fire = ar_ready_q && axil_req.arvalid;

	// write decode
	assign wr_idx   = axil_req.awaddr[4:2];
	assign wr_op    = axil_req.wdata[ctrl_op_lsb +: 2];
	assign wr_color = axil_req.wdata[ctrl_color_lsb +: 2];
	assign wr_pixel = axil_req.awaddr[1:0] == 2'b00
		&& axil_req.awaddr[7:5] == addr_pixel_base[7:5]
		&& int'(wr_idx) < lanes;
	assign wr_ctrl = axil_req.awaddr == addr_ctrl
		&& wr_op != 2'd3 && wr_color != 2'd3; // reject reserved codes

	// write channel, command and sticky done
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			aw_ready_q <= 1'b0;
			b_valid_q  <= 1'b0;
			b_resp_q   <= resp_okay;
			cmd        <= '0;
			start      <= 1'b0;
			done_q     <= 1'b0;
		end else begin
			aw_ready_q <= axil_req.awvalid && axil_req.wvalid && !b_valid_q && !aw_ready_q;
			start      <= 1'b0;
			if (done)
				done_q <= 1'b1;
			if (wr_fire) begin
				b_valid_q <= 1'b1;
				b_resp_q  <= (wr_pixel || wr_ctrl) ? resp_okay : resp_slverr;
				if (wr_ctrl) begin
					cmd <= '{
						op:     alu_op_e'(wr_op),
						color:  color_sel_e'(wr_color),
						scalar: axil_req.wdata[ctrl_scalar_lsb +: 8]
					};
					start  <= 1'b1;
					done_q <= 1'b0; // new command wins over a late done
				end
			end else if (b_valid_q && axil_req.bready) begin
				b_valid_q <= 1'b0;
			end
		end
	end

	// pixel slots with byte strobes per channel
	always_ff @(posedge clk) begin
		if (wr_fire && wr_pixel) begin
			for (int b = 0; b < 3; b++) begin
				if (axil_req.wstrb[b])
					pixels[wr_idx][8*b +: 8] <= axil_req.wdata[8*b +: 8];
			end
		end
	end

	assign rd_idx     = axil_req.araddr[4:2];
	assign carry_byte = 8'(carry);

	// read decode
	always_comb begin
		rd_data = '0;
		rd_err  = 1'b0;
		if (axil_req.araddr[1:0] != 2'b00) begin
			rd_err = 1'b1;
		end else if (axil_req.araddr[7:5] == addr_pixel_base[7:5]) begin
			if (int'(rd_idx) < lanes)
				rd_data[23:0] = pixels[rd_idx];
			else
				rd_err = 1'b1;
		end else if (axil_req.araddr == addr_ctrl) begin
			rd_data[ctrl_scalar_lsb +: 8] = cmd.scalar;
			rd_data[ctrl_op_lsb +: 2]     = cmd.op;
			rd_data[ctrl_color_lsb +: 2]  = cmd.color;
		end else if (axil_req.araddr == addr_status) begin
			rd_data[status_done_bit]       = done_q | done; // done pulse counts before it sticks
			rd_data[status_carry_lsb +: 8] = carry_byte;
		end else if (axil_req.araddr[7:5] == addr_result_base[7:5]) begin
			if (int'(rd_idx) < lanes)
				rd_data[23:0] = results[rd_idx];
			else
				rd_err = 1'b1;
		end else begin
			rd_err = 1'b1;
		end
	end

	// read channel with rdata captured at the address handshake
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ar_ready_q <= 1'b0;
			r_valid_q  <= 1'b0;
			r_resp_q   <= resp_okay;
			r_data_q   <= '0;
		end else begin
			ar_ready_q <= axil_req.arvalid && !r_valid_q && !ar_ready_q;
			if (rd_fire) begin
				r_valid_q <= 1'b1;
				r_resp_q  <= rd_err ? resp_slverr : resp_okay;
				r_data_q  <= rd_data;
			end else if (r_valid_q && axil_req.rready) begin
				r_valid_q <= 1'b0;
			end
		end
	end

	// held responses must not move until taken
	a_b_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		b_valid_q && !axil_req.bready |=> b_valid_q && $stable(b_resp_q)
	);

	a_r_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		r_valid_q && !axil_req.rready |=> r_valid_q && $stable(r_data_q) && $stable(r_resp_q)
	);

	// eight slots in the map
	a_lanes_range: assert property (
		@(posedge clk) lanes >= 1 && lanes <= 8
	);

endmodule

// File: rtl/pixel_alu_top.sv
`timescale 1ns/1ps

module pixel_alu_top import pixel_pkg::*, ctrl_pkg::*; #(
	parameter int lanes = 8
) (
	input  logic      clk,
	input  logic      rst_n,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp
);

	alu_cmd_t cmd;
	pixel_t [lanes-1:0] pixels;
	pixel_t [lanes-1:0] results;
	logic [lanes-1:0] carry;
	logic start;
	logic done;

	alu_regs #(
		.lanes (lanes)
	) u_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.cmd      (cmd),
		.pixels   (pixels),
		.start    (start),
		.results  (results),
		.carry    (carry),
		.done     (done)
	);

	// one cycle from start to results
	vector_alu #(
		.lanes (lanes)
	) u_alu (
		.clk     (clk),
		.rst_n   (rst_n),
		.cmd     (cmd),
		.pixels  (pixels),
		.start   (start),
		.results (results),
		.carry   (carry),
		.done    (done)
	);

endmodule

// File: verif/pixel_alu_tb.sv
`timescale 1ns/1ps

module pixel_alu_tb import pixel_pkg::*, ctrl_pkg::*;;

	localparam int lanes = 8;
	localparam int max_cycles = 4000; // nine op runs of ~100 cycles plus error and stall tests

	logic clk = 1'b0;
	logic rst_n;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;

	int errors = 0;
	int cycles = 0;
	logic [31:0] seed = 32'h49d5_e91d;
	pixel_t exp_res [lanes] = '{default: '0};
	logic [7:0] exp_carry = '0;

	pixel_alu_top #(
		.lanes (lanes)
	) uut (
		.clk      (clk),
		.rst_n    (rst_n),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp)
	);

	always #4 clk = ~clk;

	// hang guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == max_cycles) begin
			$display("timeout: the DUT stopped answering on the bus after %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	function automatic channel_t rand_byte();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[23:16]; // upper bits are the better ones
	endfunction

	function automatic logic [31:0] ctrl_word(logic [1:0] op, logic [1:0] color, channel_t s);
		return {20'd0, color, op, s};
	endfunction

	// expected lane result with carry in bit 24
	function automatic logic [24:0] model_lane(pixel_t p, alu_op_e op, color_sel_e c, channel_t s);
		int ch;
		int r;
		logic cy;
		pixel_t q;
		case (c)
			color_red:   ch = p.red;
			color_green: ch = p.green;
			default:     ch = p.blue;
		endcase
		case (op)
			op_add: begin
				r  = ch + s;
				cy = r > 255;
			end
			op_sub: begin
				r  = ch - s;
				cy = ch < s; // borrow
			end
			default: begin
				r  = ch * s;
				cy = r > 255;
			end
		endcase
		q = p;
		case (c)
			color_red:   q.red = r[7:0];
			color_green: q.green = r[7:0];
			default:     q.blue = r[7:0];
		endcase
		return {cy, q};
	endfunction

	task automatic compare_pixel(input string name, input pixel_t exp, input pixel_t act);
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected pixel %06h, got %06h", name, exp, act);
		end
	endtask

	task automatic compare_carry(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected carry %02h, got %02h", name, exp, act);
		end
	endtask

	task automatic compare_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected resp %0d, got %0d", name, exp, act);
		end
	endtask

	task automatic compare_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected done %0b, got %0b", name, exp, act);
		end
	endtask

	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		@(posedge clk);
		axil_req.awaddr  <= addr;
		axil_req.wdata   <= data;
		axil_req.wstrb   <= strb;
		axil_req.awvalid <= 1'b1;
		axil_req.wvalid  <= 1'b1;
		do @(posedge clk); while (!axil_rsp.awready);
		if (!axil_rsp.wready) begin
			errors++;
			$display("wready did not rise together with awready");
		end
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid  <= 1'b0;
		axil_req.bready  <= 1'b1;
		do @(posedge clk); while (!axil_rsp.bvalid);
		resp = axil_rsp.bresp;
		axil_req.bready <= 1'b0;
	endtask

	task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		axil_req.araddr  <= addr;
		axil_req.arvalid <= 1'b1;
		do @(posedge clk); while (!axil_rsp.arready);
		axil_req.arvalid <= 1'b0;
		axil_req.rready  <= 1'b1;
		do @(posedge clk); while (!axil_rsp.rvalid);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		axil_req.rready <= 1'b0;
	endtask

	// all result slots and status against the expected state
	task automatic check_state(input string name, input logic exp_done);
		logic [31:0] data;
		logic [1:0] resp;
		for (int k = 0; k < lanes; k++) begin
			axil_read(addr_result_base + 8'(4 * k), data, resp);
			compare_resp({name, " result read"}, resp_okay, resp);
			compare_pixel({name, " result"}, exp_res[k], data[23:0]);
		end
		axil_read(addr_status, data, resp);
		compare_resp({name, " status read"}, resp_okay, resp);
		compare_carry(name, exp_carry, data[15:8]);
		compare_flag(name, exp_done, data[0]);
	endtask

	task automatic run_op(input string name, input alu_op_e op, input color_sel_e c,
			input channel_t s);
		logic [1:0] resp;
		logic [24:0] m;
		pixel_t p;
		for (int k = 0; k < lanes; k++) begin
			p = {rand_byte(), rand_byte(), rand_byte()};
			axil_write(addr_pixel_base + 8'(4 * k), {8'h00, p}, 4'hf, resp);
			compare_resp({name, " pixel write"}, resp_okay, resp);
			m = model_lane(p, op, c, s);
			exp_res[k]   = m[23:0];
			exp_carry[k] = m[24];
		end
		axil_write(addr_ctrl, ctrl_word(op, c, s), 4'hf, resp);
		compare_resp({name, " ctrl write"}, resp_okay, resp);
		check_state(name, 1'b1);
	endtask

	task automatic error_cases();
		logic [31:0] data;
		logic [1:0] resp;
		axil_write(addr_ctrl, ctrl_word(2'd3, color_red, 8'h10), 4'hf, resp);
		compare_resp("reserved op", resp_slverr, resp);
		axil_write(addr_ctrl, ctrl_word(op_add, 2'd3, 8'h10), 4'hf, resp);
		compare_resp("illegal color", resp_slverr, resp);
		axil_write(addr_result_base, 32'h00ab_cdef, 4'hf, resp);
		compare_resp("result write", resp_slverr, resp);
		axil_read(8'h30, data, resp);
		compare_resp("unmapped read", resp_slverr, resp);
		if (data !== '0) begin
			errors++;
			$display("[FAIL] unmapped read: expected data %08h, got %08h", 32'h0, data);
		end
		check_state("after errors", 1'b1);
	endtask

	task automatic backpressure_hold();
		logic [31:0] held;
		logic [31:0] data;
		logic [1:0] resp;
		logic [1:0] held_resp;
		pixel_t p;
		// read held with rready low while the address moves on
		@(posedge clk);
		axil_req.araddr  <= addr_result_base;
		axil_req.arvalid <= 1'b1;
		do @(posedge clk); while (!axil_rsp.arready);
		axil_req.arvalid <= 1'b0;
		axil_req.araddr  <= addr_status;
		do @(posedge clk); while (!axil_rsp.rvalid);
		held = axil_rsp.rdata;
		compare_pixel("stalled read", exp_res[0], held[23:0]);
		repeat (5) begin
			@(posedge clk);
			if (!axil_rsp.rvalid || axil_rsp.rdata !== held) begin
				errors++;
				$display("read response changed or dropped while rready was low");
			end
		end
		axil_req.rready <= 1'b1;
		@(posedge clk);
		axil_req.rready <= 1'b0;
		@(posedge clk);
		if (axil_rsp.rvalid) begin
			errors++;
			$display("read response was delivered a second time");
		end
		// write held with bready low and a second write waiting
		p = {rand_byte(), rand_byte(), rand_byte()};
		@(posedge clk);
		axil_req.awaddr  <= addr_pixel_base;
		axil_req.wdata   <= {8'h00, p};
		axil_req.wstrb   <= 4'hf;
		axil_req.awvalid <= 1'b1;
		axil_req.wvalid  <= 1'b1;
		do @(posedge clk); while (!axil_rsp.awready);
		if (!axil_rsp.wready) begin
			errors++;
			$display("wready did not rise together with awready");
		end
		axil_req.wdata <= {8'h00, ~p};
		do @(posedge clk); while (!axil_rsp.bvalid);
		held_resp = axil_rsp.bresp;
		compare_resp("stalled write", resp_okay, held_resp);
		repeat (5) begin
			@(posedge clk);
			if (!axil_rsp.bvalid || axil_rsp.bresp !== held_resp
					|| axil_rsp.awready || axil_rsp.wready) begin
				errors++;
				$display("write response moved or a second write was taken");
			end
		end
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid  <= 1'b0;
		axil_req.bready  <= 1'b1;
		@(posedge clk);
		axil_req.bready <= 1'b0;
		@(posedge clk);
		if (axil_rsp.bvalid) begin
			errors++;
			$display("write response was delivered a second time");
		end
		axil_read(addr_pixel_base, data, resp);
		compare_resp("pixel readback", resp_okay, resp);
		compare_pixel("pixel readback", p, data[23:0]);
	endtask

	initial begin
		rst_n    <= 1'b0;
		axil_req <= '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_state("reset", 1'b0);
		run_op("add red", op_add, color_red, rand_byte());
		run_op("add green 255", op_add, color_green, 8'hff);
		run_op("add blue", op_add, color_blue, rand_byte());
		run_op("sub red", op_sub, color_red, rand_byte());
		run_op("sub green", op_sub, color_green, 8'h80);
		run_op("sub blue", op_sub, color_blue, rand_byte());
		run_op("mul red 0", op_mul, color_red, 8'h00);
		run_op("mul green 1", op_mul, color_green, 8'h01);
		run_op("mul blue", op_mul, color_blue, rand_byte());
		error_cases();
		backpressure_hold();
		$display("checks done, %0d errors", errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: verilog.f
common/pixel_pkg.sv
common/ctrl_pkg.sv
vector_alu/lane_alu.sv
vector_alu/vector_alu.sv
rtl/alu_regs.sv
rtl/pixel_alu_top.sv
verif/pixel_alu_tb.sv

// File: Makefile
TOP = pixel_alu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module pixel_alu_top

clean:
	rm -rf obj_dir sim.log
